/* rtl/sniff_pkg.sv */
// ============================
// shared constants and state types for the RMII sniffer
// capture depth is fixed here, every block follows CAP_BYTES
// RMII dibits are given as {rxd[1], rxd[0]}, rxd[0] is the earlier bit
// the capture FSM has five states, so its enum needs three bits
// ============================
package sniff_pkg;

  localparam int CAP_BYTES = 32;  // bytes stored per frame
  localparam int CAP_AW    = 5;   // log2 of CAP_BYTES

  // 0x55 preamble byte, sent LSB first, shows as 01 on every dibit
  localparam logic [1:0] DIBIT_PRE = 2'b01;
  // last dibit of the 0xD5 start-of-frame byte
  localparam logic [1:0] DIBIT_SFD = 2'b11;

  typedef enum logic [2:0]
  {
    CAP_IDLE,      // waiting for carrier with preamble
    CAP_PRE,       // inside preamble, looking for SFD
    CAP_SKIP,      // dropping leading bytes
    CAP_STORE,     // assembling and writing bytes
    CAP_WAIT_END   // full, ignored or bad frame, wait for carrier drop
  } cap_state_t;

  typedef enum logic [1:0]
  {
    DUMP_IDLE,     // nothing to send
    DUMP_REQ,      // RAM read in flight
    DUMP_HI,       // high nibble on char port
    DUMP_LO        // low nibble on char port
  } dump_state_t;

endpackage

/* rtl/rmii_capture.sv */
// ============================
// RMII receive framer, listen only
// rmii inputs must be synchronous to clk (50 MHz ref clock)
// skip_bytes is sampled on the SFD dibit
// a partial byte at carrier drop is discarded, no FCS check
// frames starting while dump_busy is high are not stored
// ============================
`timescale 1ns/1ps
module rmii_capture
  import sniff_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              rmii_crs_dv,
  input  logic [1:0]        rmii_rxd,
  input  logic [7:0]        skip_bytes,
  input  logic              dump_busy,
  output logic              m0_cyc,
  output logic              m0_stb,
  output logic              m0_we,
  output logic [CAP_AW-1:0] m0_adr,
  output logic [7:0]        m0_dat_w,
  input  logic              m0_ack,
  output logic              frame_done,
  output logic [5:0]        frame_len
);

  cap_state_t state_q;
  logic [1:0] dibit_cnt_q;  // dibit position within the byte
  logic [7:0] skip_cnt_q;   // bytes still to drop
  logic [5:0] byte_cnt_q;   // bytes stored so far
  logic [7:0] shift_q;      // LSB-first dibit shifter
  logic       accept_q;     // current frame is being captured
  logic       write_go;

  // fourth dibit of a stored byte
  assign write_go  = (state_q == CAP_STORE) && rmii_crs_dv && (dibit_cnt_q == 2'd3);
  assign m0_we     = m0_cyc;  // this master only writes
  assign frame_len = byte_cnt_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q     <= CAP_IDLE;
      dibit_cnt_q <= 2'd0;
      skip_cnt_q  <= 8'd0;
      byte_cnt_q  <= 6'd0;
      accept_q    <= 1'b0;
      frame_done  <= 1'b0;
      m0_cyc      <= 1'b0;
      m0_stb      <= 1'b0;
    end
    else
    begin
      frame_done <= 1'b0;
      if (m0_ack)
      begin
        m0_cyc <= 1'b0;  // transfer done, bus released
        m0_stb <= 1'b0;
      end
      if (write_go)
      begin
        m0_cyc     <= 1'b1;
        m0_stb     <= 1'b1;
        byte_cnt_q <= byte_cnt_q + 6'd1;
      end
      if (rmii_crs_dv)
        dibit_cnt_q <= dibit_cnt_q + 2'd1;  // wraps every byte
      if (!rmii_crs_dv)
      begin
        if (accept_q)
          frame_done <= 1'b1;  // one cycle after carrier drop
        accept_q <= 1'b0;
        state_q  <= CAP_IDLE;
      end
      else
      begin
        case (state_q)
          CAP_IDLE:
            if (rmii_rxd == DIBIT_PRE)
              state_q <= CAP_PRE;
          CAP_PRE:
            if (rmii_rxd == DIBIT_SFD)
            begin
              dibit_cnt_q <= 2'd0;  // payload starts next dibit
              if (dump_busy)
                state_q <= CAP_WAIT_END;  // let it pass unstored
              else
              begin
                accept_q   <= 1'b1;
                byte_cnt_q <= 6'd0;
                skip_cnt_q <= skip_bytes;
                state_q    <= (skip_bytes == 8'd0) ? CAP_STORE : CAP_SKIP;
              end
            end
            else if (rmii_rxd != DIBIT_PRE)
              state_q <= CAP_WAIT_END;  // broken preamble
          CAP_SKIP:
            if (dibit_cnt_q == 2'd3)
            begin
              if (skip_cnt_q == 8'd1)
                state_q <= CAP_STORE;
              skip_cnt_q <= skip_cnt_q - 8'd1;
            end
          CAP_STORE:
            if (write_go && byte_cnt_q == 6'(CAP_BYTES - 1))
              state_q <= CAP_WAIT_END;  // memory full
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rmii_crs_dv)
      shift_q <= {rmii_rxd, shift_q[7:2]};  // newest dibit into top
    if (write_go)
    begin
      m0_dat_w <= {rmii_rxd, shift_q[7:2]};  // complete byte incl. 4th dibit
      m0_adr   <= byte_cnt_q[CAP_AW-1:0];
    end
  end

endmodule

/* rtl/wb_arbiter.sv */
// ============================
// two-master Wishbone classic arbiter, fixed priority to m0
// grant is combinational while the bus is free, so a
// request reaches the slave in the same cycle
// an owner keeps the bus until it drops cyc
// ============================
`timescale 1ns/1ps
module wb_arbiter
  import sniff_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              m0_cyc,
  input  logic              m0_stb,
  input  logic              m0_we,
  input  logic [CAP_AW-1:0] m0_adr,
  input  logic [7:0]        m0_dat_w,
  output logic              m0_ack,
  input  logic              m1_cyc,
  input  logic              m1_stb,
  input  logic [CAP_AW-1:0] m1_adr,
  output logic              m1_ack,
  output logic [7:0]        m1_dat_r,
  output logic              s_cyc,
  output logic              s_stb,
  output logic              s_we,
  output logic [CAP_AW-1:0] s_adr,
  output logic [7:0]        s_dat_w,
  input  logic              s_ack,
  input  logic [7:0]        s_dat_r
);

  logic own1_q;  // m1 held the bus last cycle
  logic gnt0, gnt1;

  // m1 keeps a running transfer, otherwise m0 wins
  assign gnt0 = m0_cyc && !(own1_q && m1_cyc);
  assign gnt1 = !gnt0 && m1_cyc;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      own1_q <= 1'b0;
    else
      own1_q <= gnt1;
  end

  assign s_cyc   = (gnt0 && m0_cyc) || (gnt1 && m1_cyc);
  assign s_stb   = (gnt0 && m0_stb) || (gnt1 && m1_stb);
  assign s_we    = gnt0 && m0_we;  // m1 is read only
  assign s_adr   = gnt0 ? m0_adr : m1_adr;
  assign s_dat_w = m0_dat_w;

  assign m0_ack   = gnt0 && s_ack;  // ack only to the owner
  assign m1_ack   = gnt1 && s_ack;
  assign m1_dat_r = s_dat_r;

endmodule

/* rtl/capture_ram.sv */
// ============================
// capture memory, CAP_BYTES bytes, Wishbone classic slave
// ack one cycle after stb, single pulse per transfer
// read data is registered and valid with ack
// ============================
`timescale 1ns/1ps
module capture_ram
  import sniff_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              s_cyc,
  input  logic              s_stb,
  input  logic              s_we,
  input  logic [CAP_AW-1:0] s_adr,
  input  logic [7:0]        s_dat_w,
  output logic              s_ack,
  output logic [7:0]        s_dat_r
);

  logic [7:0] mem_q [CAP_BYTES];
  logic       req;

  assign req = s_cyc && s_stb && !s_ack;  // new access this cycle

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      s_ack <= 1'b0;
    else
      s_ack <= req;  // drops again after one cycle
  end

  always_ff @(posedge clk)
  begin
    if (req && s_we)
      mem_q[s_adr] <= s_dat_w;
    if (req)
      s_dat_r <= mem_q[s_adr];  // old data on a write, unused then
  end

endmodule

/* rtl/hex_dump.sv */
// ============================
// dumps the captured bytes as uppercase ASCII hex
// two characters per byte, high nibble first, in byte order
// char_valid/char_data hold until char_ready
// zero-length frames produce no output
// ============================
`timescale 1ns/1ps
module hex_dump
  import sniff_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              frame_done,
  input  logic [5:0]        frame_len,
  output logic              dump_busy,
  output logic              m1_cyc,
  output logic              m1_stb,
  output logic [CAP_AW-1:0] m1_adr,
  input  logic              m1_ack,
  input  logic [7:0]        m1_dat_r,
  output logic [7:0]        char_data,
  output logic              char_valid,
  output logic              char_last,
  input  logic              char_ready
);

  dump_state_t state_q;
  logic [5:0]  len_q;    // bytes in this dump
  logic [7:0]  byte_q;   // byte being printed
  logic        load_hi;
  logic        load_lo;
  logic        is_last;

  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    return (nib < 4'd10) ? (8'h30 + {4'd0, nib}) : (8'h37 + {4'd0, nib});  // '0'.., 'A'..
  endfunction

  assign load_hi   = (state_q == DUMP_REQ) && m1_ack;
  assign load_lo   = (state_q == DUMP_HI) && char_ready;
  assign is_last   = ({1'b0, m1_adr} == len_q - 6'd1);
  assign dump_busy = (state_q != DUMP_IDLE);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q    <= DUMP_IDLE;
      len_q      <= 6'd0;
      m1_adr     <= '0;
      m1_cyc     <= 1'b0;
      m1_stb     <= 1'b0;
      char_valid <= 1'b0;
      char_last  <= 1'b0;
    end
    else
    begin
      case (state_q)
        DUMP_IDLE:
          if (frame_done && frame_len != 6'd0)
          begin
            len_q   <= frame_len;
            m1_adr  <= '0;
            m1_cyc  <= 1'b1;  // first read
            m1_stb  <= 1'b1;
            state_q <= DUMP_REQ;
          end
        DUMP_REQ:
          if (load_hi)
          begin
            m1_cyc     <= 1'b0;
            m1_stb     <= 1'b0;
            char_valid <= 1'b1;
            state_q    <= DUMP_HI;
          end
        DUMP_HI:
          if (load_lo)
          begin
            char_last <= is_last;  // goes with the low nibble only
            state_q   <= DUMP_LO;
          end
        DUMP_LO:
          if (char_ready)
          begin
            char_valid <= 1'b0;
            char_last  <= 1'b0;
            if (char_last)
              state_q <= DUMP_IDLE;
            else
            begin
              m1_adr  <= m1_adr + 1'b1;  // next byte, only after char taken
              m1_cyc  <= 1'b1;
              m1_stb  <= 1'b1;
              state_q <= DUMP_REQ;
            end
          end
        default:
          state_q <= DUMP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_hi)
    begin
      byte_q    <= m1_dat_r;
      char_data <= hex_char(m1_dat_r[7:4]);
    end
    else if (load_lo)
      char_data <= hex_char(byte_q[3:0]);
  end

endmodule

/* rtl/sniff_top.sv */
// ============================
// RMII packet sniffer top, single clock domain
// clk is the 50 MHz RMII reference clock
// receive only, nothing is ever transmitted
// output is a hex character stream with valid/ready
// ============================
`timescale 1ns/1ps
module sniff_top
  import sniff_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       rmii_crs_dv,
  input  logic [1:0] rmii_rxd,
  input  logic [7:0] skip_bytes,
  output logic [7:0] char_data,
  output logic       char_valid,
  output logic       char_last,
  input  logic       char_ready
);

  logic              m0_cyc, m0_stb, m0_we, m0_ack;  // framer write port
  logic [CAP_AW-1:0] m0_adr;
  logic [7:0]        m0_dat_w;
  logic              m1_cyc, m1_stb, m1_ack;         // dumper read port
  logic [CAP_AW-1:0] m1_adr;
  logic [7:0]        m1_dat_r;
  logic              s_cyc, s_stb, s_we, s_ack;      // toward the RAM
  logic [CAP_AW-1:0] s_adr;
  logic [7:0]        s_dat_w, s_dat_r;
  logic              frame_done, dump_busy;
  logic [5:0]        frame_len;

  rmii_capture u_capture (
    .clk         (clk),
    .arst_n      (arst_n),
    .rmii_crs_dv (rmii_crs_dv),
    .rmii_rxd    (rmii_rxd),
    .skip_bytes  (skip_bytes),
    .dump_busy   (dump_busy),
    .m0_cyc      (m0_cyc),
    .m0_stb      (m0_stb),
    .m0_we       (m0_we),
    .m0_adr      (m0_adr),
    .m0_dat_w    (m0_dat_w),
    .m0_ack      (m0_ack),
    .frame_done  (frame_done),
    .frame_len   (frame_len)
  );

  hex_dump u_dump (
    .clk        (clk),
    .arst_n     (arst_n),
    .frame_done (frame_done),
    .frame_len  (frame_len),
    .dump_busy  (dump_busy),
    .m1_cyc     (m1_cyc),
    .m1_stb     (m1_stb),
    .m1_adr     (m1_adr),
    .m1_ack     (m1_ack),
    .m1_dat_r   (m1_dat_r),
    .char_data  (char_data),
    .char_valid (char_valid),
    .char_last  (char_last),
    .char_ready (char_ready)
  );

  wb_arbiter u_arb (
    .clk      (clk),
    .arst_n   (arst_n),
    .m0_cyc   (m0_cyc),
    .m0_stb   (m0_stb),
    .m0_we    (m0_we),
    .m0_adr   (m0_adr),
    .m0_dat_w (m0_dat_w),
    .m0_ack   (m0_ack),
    .m1_cyc   (m1_cyc),
    .m1_stb   (m1_stb),
    .m1_adr   (m1_adr),
    .m1_ack   (m1_ack),
    .m1_dat_r (m1_dat_r),
    .s_cyc    (s_cyc),
    .s_stb    (s_stb),
    .s_we     (s_we),
    .s_adr    (s_adr),
    .s_dat_w  (s_dat_w),
    .s_ack    (s_ack),
    .s_dat_r  (s_dat_r)
  );

  capture_ram u_ram (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_cyc   (s_cyc),
    .s_stb   (s_stb),
    .s_we    (s_we),
    .s_adr   (s_adr),
    .s_dat_w (s_dat_w),
    .s_ack   (s_ack),
    .s_dat_r (s_dat_r)
  );

endmodule

/* dv/sniff_chk.sv */
// ==============================
// handshake assertions for sniff_top, bound from here
// covers both Wishbone masters, the RAM side and the char port
// checks are idle while arst_n is low
// ==============================
`timescale 1ns/1ps
module sniff_chk
  import sniff_pkg::*;
(
  input logic              clk,
  input logic              arst_n,
  input logic              m0_cyc,
  input logic              m0_stb,
  input logic              m0_ack,
  input logic              m1_cyc,
  input logic              m1_stb,
  input logic              m1_ack,
  input logic [CAP_AW-1:0] m1_adr,
  input logic              s_cyc,
  input logic              s_stb,
  input logic [7:0]        char_data,
  input logic              char_valid,
  input logic              char_ready
);

  m0_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n) m0_stb |-> m0_cyc)
    else $error("m0 strobe without cycle");
  m1_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n) m1_stb |-> m1_cyc)
    else $error("m1 strobe without cycle");
  s_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n) s_stb |-> s_cyc)
    else $error("slave strobe without cycle");

  m0_hold: assert property (@(posedge clk) disable iff (!arst_n)
    m0_stb && !m0_ack |=> m0_stb)
    else $error("m0 strobe dropped before ack");
  m1_hold: assert property (@(posedge clk) disable iff (!arst_n)
    m1_stb && !m1_ack |=> m1_stb && $stable(m1_adr))
    else $error("m1 strobe or address changed before ack");

  char_hold: assert property (@(posedge clk) disable iff (!arst_n)
    char_valid && !char_ready |=> char_valid && $stable(char_data))
    else $error("character changed while stalled");

endmodule

bind sniff_top sniff_chk u_chk (
  .clk        (clk),
  .arst_n     (arst_n),
  .m0_cyc     (m0_cyc),
  .m0_stb     (m0_stb),
  .m0_ack     (m0_ack),
  .m1_cyc     (m1_cyc),
  .m1_stb     (m1_stb),
  .m1_ack     (m1_ack),
  .m1_adr     (m1_adr),
  .s_cyc      (s_cyc),
  .s_stb      (s_stb),
  .char_data  (char_data),
  .char_valid (char_valid),
  .char_ready (char_ready)
);

/* dv/sniff_tb.sv */
// ==============================
// testbench for the RMII sniffer top
// frames, skip counts, stall and overlap flags come from dv/sniff_stim.txt
// expected hex text is built from the payload bytes
// inputs move DRV_DLY after posedge, the character port is sampled at negedge
// stops at the first error, a watchdog bounds the run time
// ==============================
`timescale 1ns/1ps
module sniff_tb
  import sniff_pkg::*;
();

  localparam int          HALF_PERIOD = 50;  // 100 ns clock
  localparam int          DRV_DLY     = 2;   // input skew after posedge
  localparam int          PRE_DIBITS  = 31;  // 7 x 0x55 plus first three dibits of 0xD5
  localparam int          GAP_CYCLES  = 6;   // idle carrier between frames
  localparam int          CHAR_BUDGET = 16;  // watchdog cycles per character
  localparam int          STIM_WORDS  = 512;
  localparam logic [31:0] SEED        = 32'h6e72_68a2;

  logic       clk;
  logic       arst_n;
  logic       rmii_crs_dv;
  logic [1:0] rmii_rxd;
  logic [7:0] skip_bytes;
  logic [7:0] char_data;
  logic       char_valid;
  logic       char_last;
  logic       char_ready;

  logic [7:0]  stim_mem [STIM_WORDS];  // flat stimulus words
  logic [7:0]  exp_chars [$];          // characters still to come
  logic        exp_last [$];           // char_last per expected character
  logic [31:0] lcg_q;
  logic        stall_en;               // random back-pressure on
  logic        hold_ready;             // char port frozen during an overlap frame
  int          timeout_cycles = 0;

  sniff_top dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .rmii_crs_dv (rmii_crs_dv),
    .rmii_rxd    (rmii_rxd),
    .skip_bytes  (skip_bytes),
    .char_data   (char_data),
    .char_valid  (char_valid),
    .char_last   (char_last),
    .char_ready  (char_ready)
  );

  always #(HALF_PERIOD) clk = ~clk;

  function automatic logic [31:0] next_rand(input logic [31:0] cur);
    return cur * 32'd1664525 + 32'd1013904223;  // plain LCG step
  endfunction

  function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
    string digits;
    digits = "0123456789ABCDEF";
    return digits[int'(nib)];
  endfunction

  // bytes that survive the skip and the capture depth
  function automatic int kept_bytes(input int count, input int skip);
    int left;
    left = (count > skip) ? count - skip : 0;
    return (left > CAP_BYTES) ? CAP_BYTES : left;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want)
      abort_run($sformatf("Mismatch at %0t: %s got %0h, expected %0h", $time, what, got, want));
  endtask

  task automatic send_dibit(input logic [1:0] dibit, input logic dv);
    @(posedge clk);
    #(DRV_DLY);
    rmii_crs_dv = dv;
    rmii_rxd    = dibit;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) send_dibit(2'b00, 1'b0);
  endtask

  task automatic send_frame(input int base, input int count, input int skip);
    logic [7:0] cur;
    send_dibit(DIBIT_PRE, 1'b1);
    skip_bytes = 8'(skip);  // taken by the DUT at the SFD dibit
    for (int i = 1; i < PRE_DIBITS; i++)
      send_dibit(DIBIT_PRE, 1'b1);
    send_dibit(DIBIT_SFD, 1'b1);
    for (int b = 0; b < count; b++)
    begin
      cur = stim_mem[base + b];
      for (int d = 0; d < 4; d++)
        send_dibit(cur[2*d +: 2], 1'b1);  // LSB first
    end
    send_dibit(2'b00, 1'b0);  // carrier off
  endtask

  task automatic queue_expected(input int base, input int count, input int skip);
    int         kept;
    logic [7:0] cur;
    kept = kept_bytes(count, skip);
    for (int i = 0; i < kept; i++)
    begin
      cur = stim_mem[base + skip + i];
      exp_chars.push_back(hex_ascii(cur[7:4]));
      exp_last.push_back(1'b0);
      exp_chars.push_back(hex_ascii(cur[3:0]));
      exp_last.push_back(i == kept - 1);  // last flag on the low nibble
    end
  endtask

  task automatic wait_drain();
    while (exp_chars.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);  // dumper back in idle
  endtask

  always @(posedge clk)
  begin
    #(DRV_DLY);
    if (hold_ready)
      char_ready = 1'b0;
    else if (stall_en)
    begin
      lcg_q      = next_rand(lcg_q);
      char_ready = lcg_q[16];  // about half the cycles stalled
    end
    else
      char_ready = 1'b1;
  end

  // a transfer happens at the next posedge when both are high here
  always @(negedge clk)
  begin : char_monitor
    logic [7:0] want_char;
    logic       want_last;
    if (arst_n && char_valid && char_ready)
    begin
      if (exp_chars.size() == 0)
        abort_run($sformatf("unexpected character %0h came out at %0t", char_data, $time));
      else
      begin
        want_char = exp_chars.pop_front();
        want_last = exp_last.pop_front();
        check_equal(32'(char_data), 32'(want_char), "char_data");
        check_equal(32'(char_last), 32'(want_last), "char_last");
      end
    end
  end

  initial
  begin : watchdog
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    abort_run("timeout, the character stream did not finish in time");
  end

  initial
  begin : main_seq
    int pos;
    int nframes;
    int count;
    int skip;
    int limit;
    clk         = 1'b0;
    arst_n      = 1'b0;
    rmii_crs_dv = 1'b0;
    rmii_rxd    = 2'b00;
    skip_bytes  = 8'd0;
    char_ready  = 1'b0;
    stall_en    = 1'b0;
    hold_ready  = 1'b0;
    lcg_q       = SEED;
    $readmemh("dv/sniff_stim.txt", stim_mem);
    nframes = int'(stim_mem[0]);
    pos     = 1;
    limit   = 100;  // reset and tail
    for (int f = 0; f < nframes; f++)
    begin
      count  = int'(stim_mem[pos + 3]);
      limit += PRE_DIBITS + 2 + 4 * count + GAP_CYCLES + 8;
      limit += 2 * CHAR_BUDGET * kept_bytes(count, int'(stim_mem[pos]));
      pos   += 4 + count;
    end
    timeout_cycles = limit;
    repeat (2) @(posedge clk);
    #(DRV_DLY);
    arst_n = 1'b1;
    pos    = 1;
    for (int f = 0; f < nframes; f++)
    begin
      skip  = int'(stim_mem[pos]);
      count = int'(stim_mem[pos + 3]);
      if (stim_mem[pos + 2] == 8'h00)  // normal frame, previous dump drains first
      begin
        wait_drain();
        stall_en = stim_mem[pos + 1][0];
        queue_expected(pos + 4, count, skip);
      end
      else
        hold_ready = 1'b1;  // dump parked on an early byte so its unread bytes are exposed
      send_frame(pos + 4, count, skip);  // overlap frame lands mid-dump
      hold_ready = 1'b0;
      idle_cycles(GAP_CYCLES);
      pos += 4 + count;
    end
    wait_drain();
    idle_cycles(20);  // no stray characters after the last dump
    $display("test passed");
    $finish;
  end

endmodule

/* dv/sniff_stim.txt */
// first word: frame count; per frame: skip stall overlap count, then count payload bytes
// stall 1 drops char_ready at random, overlap 1 sends the frame while the last dump runs
09
00 00 00 0A
12 34 56 78 9A BC DE F0 A5 5A
03 00 00 0C
01 02 03 C0 FF EE 11 22 33 44 55 66
02 00 00 28
00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE FF
F0 E1 D2 C3 B4 A5 96 87 78 69 5A 4B 3C 2D 1E 0F
DE AD BE EF 13 57 9B DF
01 01 00 14
7E 81 42 24 18 3C 66 99 C3 A5 5A 0F F0 33 CC 55 AA 01 80 FE
04 00 00 04
AB CD EF 01
00 00 00 06
0D 0E 0A 0D 0B 0E
00 01 00 22
10 20 30 40 50 60 70 80 90 A0 B0 C0 D0 E0 F0 01
12 23 34 45 56 67 78 89 9A AB BC CD DE EF F1 E2
D3 C4
00 00 01 08
55 55 D5 D5 AA AA FF 00
00 00 00 03
C0 FF EE

/* sim.f */
rtl/sniff_pkg.sv
rtl/rmii_capture.sv
rtl/wb_arbiter.sv
rtl/capture_ram.sv
rtl/hex_dump.sv
rtl/sniff_top.sv
dv/sniff_chk.sv
dv/sniff_tb.sv

/* run.sh */
#!/bin/sh
# build and run the RMII sniffer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module sniff_tb -f sim.f -o sniff_sim
./obj_dir/sniff_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "test failed" sim.log; then
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  exit 1
fi
exit 0
